//--- src.f
hdl/rename_pkg.sv
hdl/rename_table.sv
hdl/free_list.sv
hdl/rename_stage.sv
hdl/rename_top.sv
test/rename_props.sv
test/tb_rename.sv

//--- test/tb_rename.sv
`timescale 1ns/10ps

module tb_rename;

    import rename_pkg::*;

    localparam int FW    = 4;
    localparam int NUM_W = $clog2(FW + 1);

    logic                 clk;
    logic                 rst;
    logic     [FW-1:0]    in_en;
    logic     [FW-1:0]    in_we;
    areg_t    [FW-1:0]    in_rs1;
    areg_t    [FW-1:0]    in_rs2;
    areg_t    [FW-1:0]    in_rd;
    logic                 stall;
    logic                 redirect;
    rob_idx_t             rob_base;
    logic     [FW-1:0]    commit_en;
    preg_t    [FW-1:0]    commit_old_prd;
    logic                 full;
    logic     [NUM_W-1:0] valid_num;
    logic     [FW-1:0]    out_en;
    logic     [FW-1:0]    out_wen;
    preg_t    [FW-1:0]    out_prs1;
    preg_t    [FW-1:0]    out_prs2;
    preg_t    [FW-1:0]    out_prd;
    preg_t    [FW-1:0]    out_old_prd;
    rob_idx_t [FW-1:0]    out_rob_idx;

    //////////////////////////////////////////////////
    // reference model state
    //////////////////////////////////////////////////

    preg_t         map_m    [ARCH_REGS];
    preg_t         free_q   [$];
    preg_t         inflight [$];
    logic [FW-1:0] exp_en;
    logic [FW-1:0] exp_wen;
    preg_t         exp_prs1 [FW];
    preg_t         exp_prs2 [FW];
    preg_t         exp_prd  [FW];
    preg_t         exp_old  [FW];
    rob_idx_t      exp_rob  [FW];
    bit            have_group;

    string test_name;
    int    test_checks;
    int    test_errors;
    int    total_checks;
    int    total_errors;

    rename_top #(
        .FETCH_WIDTH (FW)
    ) u_rename_top (
        .clk            (clk),
        .rst            (rst),
        .in_en          (in_en),
        .in_we          (in_we),
        .in_rs1         (in_rs1),
        .in_rs2         (in_rs2),
        .in_rd          (in_rd),
        .stall          (stall),
        .redirect       (redirect),
        .rob_base       (rob_base),
        .commit_en      (commit_en),
        .commit_old_prd (commit_old_prd),
        .full           (full),
        .valid_num      (valid_num),
        .out_en         (out_en),
        .out_wen        (out_wen),
        .out_prs1       (out_prs1),
        .out_prs2       (out_prs2),
        .out_prd        (out_prd),
        .out_old_prd    (out_old_prd),
        .out_rob_idx    (out_rob_idx)
    );

    always #5 clk = ~clk;

    // mostly a few low registers so slots in one group collide
    function automatic areg_t pick_reg();
        if ($urandom_range(3) == 0) begin
            return areg_t'($urandom);
        end
        return areg_t'($urandom_range(5));
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        test_checks++;
        assert (got === exp) else begin
            test_errors++;
            $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic compare_outputs();
        check_val("out_en", out_en, exp_en);
        check_val("out_wen", out_wen, exp_wen);
        if (have_group) begin
            for (int i = 0; i < FW; i++) begin
                check_val($sformatf("out_prs1[%0d]", i), out_prs1[i], exp_prs1[i]);
                check_val($sformatf("out_prs2[%0d]", i), out_prs2[i], exp_prs2[i]);
                check_val($sformatf("out_prd[%0d]", i), out_prd[i], exp_prd[i]);
                check_val($sformatf("out_old_prd[%0d]", i), out_old_prd[i], exp_old[i]);
                check_val($sformatf("out_rob_idx[%0d]", i), out_rob_idx[i], exp_rob[i]);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // model: rename slots one after another
    //////////////////////////////////////////////////

    task automatic model_group(
        input logic st, input logic rdr, input logic [FW-1:0] en, input logic [FW-1:0] we,
        input areg_t [FW-1:0] rs1, input areg_t [FW-1:0] rs2, input areg_t [FW-1:0] rd,
        input rob_idx_t base, input logic [FW-1:0] cen, input preg_t [FW-1:0] cprd
    );
        preg_t work [ARCH_REGS];
        preg_t np;
        logic  wr;
        bit    fire;
        fire = !st && !rdr && free_q.size() >= FW;
        if (rdr) begin
            exp_en  = '0;
            exp_wen = '0;
        end else if (fire) begin
            work = map_m;
            for (int i = 0; i < FW; i++) begin
                wr          = en[i] && we[i] && rd[i] != '0;
                exp_prs1[i] = work[rs1[i]];
                exp_prs2[i] = work[rs2[i]];
                exp_old[i]  = work[rd[i]];
                np          = '0;
                if (wr) begin
                    np          = free_q.pop_front();
                    work[rd[i]] = np;
                    inflight.push_back(exp_old[i]);
                end
                exp_prd[i] = np;
                exp_wen[i] = wr;
                // a plain add over index and wrap bit flips the wrap bit past the end
                exp_rob[i] = rob_idx_t'(base + i);
            end
            exp_en     = en;
            map_m      = work;
            have_group = 1'b1;
        end
        // returned registers land behind this cycle's pops
        for (int i = 0; i < FW; i++) begin
            if (cen[i] && cprd[i] != '0) begin
                free_q.push_back(cprd[i]);
            end
        end
    endtask

    task automatic run_cycle(input int stall_pct, input int redir_pct, input int en_pct,
                             input int we_pct, input int commit_pct);
        logic          st;
        logic          rdr;
        logic [FW-1:0] en;
        logic [FW-1:0] we;
        logic [FW-1:0] cen;
        areg_t [FW-1:0] rs1;
        areg_t [FW-1:0] rs2;
        areg_t [FW-1:0] rd;
        preg_t [FW-1:0] cprd;
        rob_idx_t      base;
        int            n_valid;
        st   = $urandom_range(99) < stall_pct;
        rdr  = $urandom_range(99) < redir_pct;
        base = rob_idx_t'($urandom);
        for (int i = 0; i < FW; i++) begin
            en[i]   = $urandom_range(99) < en_pct;
            we[i]   = $urandom_range(99) < we_pct;
            rs1[i]  = pick_reg();
            rs2[i]  = pick_reg();
            rd[i]   = pick_reg();
            cen[i]  = 1'b0;
            cprd[i] = '0;
            if ($urandom_range(99) < commit_pct && inflight.size() > 0) begin
                cen[i]  = 1'b1;
                cprd[i] = inflight.pop_front();
            end else if ($urandom_range(15) == 0) begin
                // commit of an instruction with no old register to return
                cen[i] = 1'b1;
            end
        end
        @(posedge clk);
        in_en          <= en;
        in_we          <= we;
        in_rs1         <= rs1;
        in_rs2         <= rs2;
        in_rd          <= rd;
        stall          <= st;
        redirect       <= rdr;
        rob_base       <= base;
        commit_en      <= cen;
        commit_old_prd <= cprd;
        @(negedge clk);
        compare_outputs();
        n_valid = 0;
        for (int i = 0; i < FW; i++) begin
            n_valid += en[i];
        end
        check_val("valid_num", valid_num, n_valid);
        check_val("full", full, free_q.size() < FW);
        model_group(st, rdr, en, we, rs1, rs2, rd, base, cen, cprd);
    endtask

    task automatic wait_for_full(input logic level, input int stall_pct, input int commit_pct,
                                 input string what);
        int cnt;
        cnt = 0;
        while (full !== level && cnt < 100) begin
            run_cycle(stall_pct, 0, 100, 100, commit_pct);
            cnt++;
        end
        if (full !== level) begin
            $display("timeout: %s", what);
            $display("Test FAILED");
            $finish;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("%-16s %0d checks, %0d errors", test_name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        in_en          = '0;
        in_we          = '0;
        in_rs1         = '0;
        in_rs2         = '0;
        in_rd          = '0;
        stall          = 1'b1;
        redirect       = 1'b0;
        rob_base       = '0;
        commit_en      = '0;
        commit_old_prd = '0;
        void'($urandom(32'he3f1_4550));
        total_checks = 0;
        total_errors = 0;
        exp_en       = '0;
        exp_wen      = '0;
        have_group   = 1'b0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            map_m[i] = preg_t'(i);
        end
        for (int i = ARCH_REGS; i < PHYS_REGS; i++) begin
            free_q.push_back(preg_t'(i));
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        start_test("mixed traffic");
        repeat (400) run_cycle(15, 8, 75, 70, 40);
        end_test();

        start_test("redirect");
        repeat (40) run_cycle(0, 50, 100, 70, 30);
        end_test();

        start_test("stall hold");
        repeat (30) run_cycle(100, 0, 100, 100, 0);
        end_test();

        start_test("fill to full");
        wait_for_full(1'b1, 0, 0, "free list never reported full");
        repeat (10) run_cycle(0, 0, 100, 100, 0);
        end_test();

        start_test("commit release");
        wait_for_full(1'b0, 100, 100, "full did not clear after commits");
        repeat (20) run_cycle(0, 0, 100, 100, 50);
        run_cycle(100, 0, 0, 0, 0);
        end_test();

        total_errors += u_rename_top.u_rename_props.fail_count;
        $display("total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- test/rename_props.sv
`timescale 1ns/10ps

module rename_props #(
    parameter int FETCH_WIDTH = 4
) (
    input logic                                        clk,
    input logic                                        rst,
    input logic                                        stall,
    input logic                                        full,
    input logic                                        redirect,
    input logic                                        alloc_fire,
    input logic                 [FETCH_WIDTH-1:0]      out_en,
    input logic                 [FETCH_WIDTH-1:0]      out_wen,
    input rename_pkg::preg_t    [FETCH_WIDTH-1:0]      out_prs1,
    input rename_pkg::preg_t    [FETCH_WIDTH-1:0]      out_prs2,
    input rename_pkg::preg_t    [FETCH_WIDTH-1:0]      out_prd,
    input rename_pkg::preg_t    [FETCH_WIDTH-1:0]      out_old_prd,
    input rename_pkg::rob_idx_t [FETCH_WIDTH-1:0]      out_rob_idx
);

    import rename_pkg::*;

    // output data is unknown until the first group fires
    logic fired_q;

    int fail_count = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            fired_q <= 1'b0;
        end else if (alloc_fire) begin
            fired_q <= 1'b1;
        end
    end

    assert property (@(posedge clk) rst |=> out_en == '0)
        else begin
            fail_count++;
            $error("out_en not clear after reset");
        end

    for (genvar i = 0; i < FETCH_WIDTH; i++) begin : g_slot
        assert property (@(posedge clk) disable iff (rst)
            out_wen[i] |-> out_prd[i] != preg_t'(0))
            else begin
                fail_count++;
                $error("slot %0d writes physical register 0", i);
            end
        for (genvar j = i + 1; j < FETCH_WIDTH; j++) begin : g_pair
            assert property (@(posedge clk) disable iff (rst)
                out_wen[i] && out_wen[j] |-> out_prd[i] != out_prd[j])
                else begin
                    fail_count++;
                    $error("slots %0d and %0d share a new register", i, j);
                end
        end
    end

    // a held group stays on the outputs
    assert property (@(posedge clk) disable iff (rst)
        fired_q && (full || stall) && !redirect |=>
            $stable(out_en) && $stable(out_wen) && $stable(out_prs1) &&
            $stable(out_prs2) && $stable(out_prd) && $stable(out_old_prd) &&
            $stable(out_rob_idx))
        else begin
            fail_count++;
            $error("outputs changed while stalled or full");
        end

endmodule

bind rename_top rename_props #(
    .FETCH_WIDTH (FETCH_WIDTH)
) u_rename_props (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .full        (full),
    .redirect    (redirect),
    .alloc_fire  (alloc_fire),
    .out_en      (out_en),
    .out_wen     (out_wen),
    .out_prs1    (out_prs1),
    .out_prs2    (out_prs2),
    .out_prd     (out_prd),
    .out_old_prd (out_old_prd),
    .out_rob_idx (out_rob_idx)
);

//--- hdl/rename_top.sv
`timescale 1ns/10ps

module rename_top #(
    parameter  int FETCH_WIDTH = 4,
    localparam int NUM_W       = $clog2(FETCH_WIDTH + 1)
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                 [FETCH_WIDTH-1:0]      in_en,
    input  logic                 [FETCH_WIDTH-1:0]      in_we,
    input  rename_pkg::areg_t    [FETCH_WIDTH-1:0]      in_rs1,
    input  rename_pkg::areg_t    [FETCH_WIDTH-1:0]      in_rs2,
    input  rename_pkg::areg_t    [FETCH_WIDTH-1:0]      in_rd,
    input  logic                                        stall,
    input  logic                                        redirect,
    input  rename_pkg::rob_idx_t                        rob_base,
    input  logic                 [FETCH_WIDTH-1:0]      commit_en,
    input  rename_pkg::preg_t    [FETCH_WIDTH-1:0]      commit_old_prd,
    output logic                                        full,
    output logic                 [NUM_W-1:0]            valid_num,
    output logic                 [FETCH_WIDTH-1:0]      out_en,
    output logic                 [FETCH_WIDTH-1:0]      out_wen,
    output rename_pkg::preg_t    [FETCH_WIDTH-1:0]      out_prs1,
    output rename_pkg::preg_t    [FETCH_WIDTH-1:0]      out_prs2,
    output rename_pkg::preg_t    [FETCH_WIDTH-1:0]      out_prd,
    output rename_pkg::preg_t    [FETCH_WIDTH-1:0]      out_old_prd,
    output rename_pkg::rob_idx_t [FETCH_WIDTH-1:0]      out_rob_idx
);

    // stage <-> table
    rename_pkg::areg_t [FETCH_WIDTH-1:0] rd_areg_rs1;
    rename_pkg::areg_t [FETCH_WIDTH-1:0] rd_areg_rs2;
    rename_pkg::areg_t [FETCH_WIDTH-1:0] rd_areg_rd;
    rename_pkg::preg_t [FETCH_WIDTH-1:0] prs1;
    rename_pkg::preg_t [FETCH_WIDTH-1:0] prs2;
    rename_pkg::preg_t [FETCH_WIDTH-1:0] old_prd;
    logic              [FETCH_WIDTH-1:0] wr_en;
    rename_pkg::areg_t [FETCH_WIDTH-1:0] wr_areg;
    rename_pkg::preg_t [FETCH_WIDTH-1:0] wr_preg;

    // stage <-> free list
    logic                                alloc_fire;
    logic              [NUM_W-1:0]       alloc_num;
    rename_pkg::preg_t [FETCH_WIDTH-1:0] alloc_prd;

    rename_stage #(
        .FETCH_WIDTH (FETCH_WIDTH)
    ) u_rename_stage (
        .clk         (clk),
        .rst         (rst),
        .in_en       (in_en),
        .in_we       (in_we),
        .in_rs1      (in_rs1),
        .in_rs2      (in_rs2),
        .in_rd       (in_rd),
        .stall       (stall),
        .redirect    (redirect),
        .rob_base    (rob_base),
        .prs1        (prs1),
        .prs2        (prs2),
        .old_prd     (old_prd),
        .alloc_prd   (alloc_prd),
        .full        (full),
        .rd_areg_rs1 (rd_areg_rs1),
        .rd_areg_rs2 (rd_areg_rs2),
        .rd_areg_rd  (rd_areg_rd),
        .wr_en       (wr_en),
        .wr_areg     (wr_areg),
        .wr_preg     (wr_preg),
        .alloc_fire  (alloc_fire),
        .alloc_num   (alloc_num),
        .valid_num   (valid_num),
        .out_en      (out_en),
        .out_wen     (out_wen),
        .out_prs1    (out_prs1),
        .out_prs2    (out_prs2),
        .out_prd     (out_prd),
        .out_old_prd (out_old_prd),
        .out_rob_idx (out_rob_idx)
    );

    rename_table #(
        .FETCH_WIDTH (FETCH_WIDTH)
    ) u_rename_table (
        .clk     (clk),
        .rst     (rst),
        .rs1     (rd_areg_rs1),
        .rs2     (rd_areg_rs2),
        .rd      (rd_areg_rd),
        .wr_en   (wr_en),
        .wr_areg (wr_areg),
        .wr_preg (wr_preg),
        .prs1    (prs1),
        .prs2    (prs2),
        .old_prd (old_prd)
    );

    // commit slots push straight into the free list
    free_list #(
        .FETCH_WIDTH (FETCH_WIDTH)
    ) u_free_list (
        .clk        (clk),
        .rst        (rst),
        .alloc_fire (alloc_fire),
        .alloc_num  (alloc_num),
        .push_en    (commit_en),
        .push_prd   (commit_old_prd),
        .alloc_prd  (alloc_prd),
        .full       (full)
    );

endmodule

//--- hdl/rename_stage.sv
`timescale 1ns/10ps

module rename_stage #(
    parameter  int FETCH_WIDTH = 4,
    localparam int NUM_W       = $clog2(FETCH_WIDTH + 1)
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                 [FETCH_WIDTH-1:0]      in_en,
    input  logic                 [FETCH_WIDTH-1:0]      in_we,
    input  rename_pkg::areg_t    [FETCH_WIDTH-1:0]      in_rs1,
    input  rename_pkg::areg_t    [FETCH_WIDTH-1:0]      in_rs2,
    input  rename_pkg::areg_t    [FETCH_WIDTH-1:0]      in_rd,
    input  logic                                        stall,
    input  logic                                        redirect,
    input  rename_pkg::rob_idx_t                        rob_base,
    input  rename_pkg::preg_t    [FETCH_WIDTH-1:0]      prs1,
    input  rename_pkg::preg_t    [FETCH_WIDTH-1:0]      prs2,
    input  rename_pkg::preg_t    [FETCH_WIDTH-1:0]      old_prd,
    input  rename_pkg::preg_t    [FETCH_WIDTH-1:0]      alloc_prd,
    input  logic                                        full,
    output rename_pkg::areg_t    [FETCH_WIDTH-1:0]      rd_areg_rs1,
    output rename_pkg::areg_t    [FETCH_WIDTH-1:0]      rd_areg_rs2,
    output rename_pkg::areg_t    [FETCH_WIDTH-1:0]      rd_areg_rd,
    output logic                 [FETCH_WIDTH-1:0]      wr_en,
    output rename_pkg::areg_t    [FETCH_WIDTH-1:0]      wr_areg,
    output rename_pkg::preg_t    [FETCH_WIDTH-1:0]      wr_preg,
    output logic                                        alloc_fire,
    output logic                 [NUM_W-1:0]            alloc_num,
    output logic                 [NUM_W-1:0]            valid_num,
    output logic                 [FETCH_WIDTH-1:0]      out_en,
    output logic                 [FETCH_WIDTH-1:0]      out_wen,
    output rename_pkg::preg_t    [FETCH_WIDTH-1:0]      out_prs1,
    output rename_pkg::preg_t    [FETCH_WIDTH-1:0]      out_prs2,
    output rename_pkg::preg_t    [FETCH_WIDTH-1:0]      out_prd,
    output rename_pkg::preg_t    [FETCH_WIDTH-1:0]      out_old_prd,
    output rename_pkg::rob_idx_t [FETCH_WIDTH-1:0]      out_rob_idx
);

    import rename_pkg::*;

    logic [FETCH_WIDTH-1:0] rd_en;
    logic [FETCH_WIDTH-1:0] waw;
    logic [NUM_W-1:0]       alloc_pos [FETCH_WIDTH];
    preg_t                  new_prd   [FETCH_WIDTH];
    preg_t                  byp_rs1   [FETCH_WIDTH];
    preg_t                  byp_rs2   [FETCH_WIDTH];
    preg_t                  byp_old   [FETCH_WIDTH];
    logic [ROB_W:0]         rob_sum   [FETCH_WIDTH];
    rob_idx_t               rob_idx   [FETCH_WIDTH];

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            rd_en[i] = in_en[i] && in_we[i] && in_rd[i] != '0;
        end
    end

    assign alloc_fire  = ~stall & ~full & ~redirect;
    assign rd_areg_rs1 = in_rs1;
    assign rd_areg_rs2 = in_rs2;
    assign rd_areg_rd  = in_rd;

    //////////////////////////////////////////////////
    // allocation and counts
    //////////////////////////////////////////////////

    // slot i takes the free entry at the count of older writers
    always_comb begin
        alloc_num = '0;
        valid_num = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            alloc_pos[i] = alloc_num;
            new_prd[i]   = rd_en[i] ? alloc_prd[alloc_pos[i]] : '0;
            alloc_num    = alloc_num + NUM_W'(rd_en[i]);
            valid_num    = valid_num + NUM_W'(in_en[i]);
        end
    end

    //////////////////////////////////////////////////
    // in-group dependencies
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            byp_rs1[i] = prs1[i];
            byp_rs2[i] = prs2[i];
            byp_old[i] = old_prd[i];
            // scan oldest to youngest so the nearest older writer wins
            for (int j = 0; j < i; j++) begin
                if (rd_en[j] && in_rd[j] == in_rs1[i]) begin
                    byp_rs1[i] = new_prd[j];
                end
                if (rd_en[j] && in_rd[j] == in_rs2[i]) begin
                    byp_rs2[i] = new_prd[j];
                end
                if (rd_en[j] && in_rd[j] == in_rd[i]) begin
                    byp_old[i] = new_prd[j];
                end
            end
            // a younger writer of the same rd owns the table entry
            waw[i] = 1'b0;
            for (int j = i + 1; j < FETCH_WIDTH; j++) begin
                if (rd_en[j] && in_rd[j] == in_rd[i]) begin
                    waw[i] = 1'b1;
                end
            end
            wr_preg[i] = new_prd[i];
        end
    end

    assign wr_en   = {FETCH_WIDTH{alloc_fire}} & rd_en & ~waw;
    assign wr_areg = in_rd;

    //////////////////////////////////////////////////
    // rob index
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            rob_sum[i] = (ROB_W + 1)'(rob_base[ROB_W-1:0]) + (ROB_W + 1)'(i);
            if (rob_sum[i] >= (ROB_W + 1)'(ROB_DEPTH)) begin
                rob_idx[i] = {~rob_base[ROB_W], ROB_W'(rob_sum[i] - (ROB_W + 1)'(ROB_DEPTH))};
            end else begin
                rob_idx[i] = {rob_base[ROB_W], rob_sum[i][ROB_W-1:0]};
            end
        end
    end

    //////////////////////////////////////////////////
    // toward dispatch
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            out_en  <= '0;
            out_wen <= '0;
        end else if (alloc_fire) begin
            out_en  <= in_en;
            out_wen <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                out_prs1[i]    <= byp_rs1[i];
                out_prs2[i]    <= byp_rs2[i];
                out_prd[i]     <= new_prd[i];
                out_old_prd[i] <= byp_old[i];
                out_rob_idx[i] <= rob_idx[i];
            end
        end
    end

endmodule

//--- hdl/free_list.sv
`timescale 1ns/10ps

module free_list #(
    parameter  int FETCH_WIDTH = 4,
    localparam int NUM_W       = $clog2(FETCH_WIDTH + 1)
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    alloc_fire,
    input  logic              [NUM_W-1:0]           alloc_num,
    input  logic              [FETCH_WIDTH-1:0]     push_en,
    input  rename_pkg::preg_t [FETCH_WIDTH-1:0]     push_prd,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]     alloc_prd,
    output logic                                    full
);

    import rename_pkg::*;

    localparam int PTR_W = $clog2(PHYS_REGS);
    localparam int CNT_W = $clog2(PHYS_REGS + 1);

    // registers 32..63 start out free
    localparam int INIT_FREE = PHYS_REGS - ARCH_REGS;

    preg_t             fifo_q [PHYS_REGS];
    logic [PTR_W-1:0]  head_q;
    logic [PTR_W-1:0]  tail_q;
    logic [CNT_W-1:0]  count_q;

    logic [PTR_W-1:0]  rd_ptr   [FETCH_WIDTH];
    logic [PTR_W-1:0]  wr_ptr   [FETCH_WIDTH];
    logic [FETCH_WIDTH-1:0] push_vld;
    logic [NUM_W-1:0]  push_num;
    logic [NUM_W-1:0]  pop_num;

    //////////////////////////////////////////////////
    // pointers
    //////////////////////////////////////////////////

    // p0 is never returned to the pool
    assign push_vld = push_en & valid_mask(push_prd);

    // pushes land at compacted slots past the tail, lower commit slot first
    always_comb begin
        push_num = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            rd_ptr[i] = head_q + PTR_W'(i);
            wr_ptr[i] = tail_q + PTR_W'(push_num);
            push_num  = push_num + NUM_W'(push_vld[i]);
        end
    end

    assign pop_num = alloc_fire ? alloc_num : '0;

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            alloc_prd[i] = fifo_q[rd_ptr[i]];
        end
    end

    // independent of the group currently being renamed
    assign full = count_q < CNT_W'(FETCH_WIDTH);

    //////////////////////////////////////////////////
    // state
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= PTR_W'(INIT_FREE);
            count_q <= CNT_W'(INIT_FREE);
        end else begin
            head_q  <= head_q + PTR_W'(pop_num);
            tail_q  <= tail_q + PTR_W'(push_num);
            count_q <= count_q + CNT_W'(push_num) - CNT_W'(pop_num);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < INIT_FREE; i++) begin
                fifo_q[i] <= preg_t'(ARCH_REGS + i);
            end
        end else begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (push_vld[i]) begin
                    fifo_q[wr_ptr[i]] <= push_prd[i];
                end
            end
        end
    end

    function automatic logic [FETCH_WIDTH-1:0] valid_mask(
        input preg_t [FETCH_WIDTH-1:0] prd
    );
        logic [FETCH_WIDTH-1:0] mask;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            mask[i] = prd[i] != '0;
        end
        return mask;
    endfunction

endmodule

//--- hdl/rename_table.sv
`timescale 1ns/10ps

module rename_table #(
    parameter int FETCH_WIDTH = 4
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  rename_pkg::areg_t [FETCH_WIDTH-1:0]     rs1,
    input  rename_pkg::areg_t [FETCH_WIDTH-1:0]     rs2,
    input  rename_pkg::areg_t [FETCH_WIDTH-1:0]     rd,
    input  logic              [FETCH_WIDTH-1:0]     wr_en,
    input  rename_pkg::areg_t [FETCH_WIDTH-1:0]     wr_areg,
    input  rename_pkg::preg_t [FETCH_WIDTH-1:0]     wr_preg,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]     prs1,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]     prs2,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]     old_prd
);

    import rename_pkg::*;

    // speculative arch -> phys map
    preg_t map_q [ARCH_REGS];

    //////////////////////////////////////////////////
    // update
    //////////////////////////////////////////////////

    // identity map out of reset
    // writes never share an areg within one group
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= preg_t'(i);
            end
        end else begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                // x0 stays pinned to p0
                if (wr_en[i] && wr_areg[i] != '0) begin
                    map_q[wr_areg[i]] <= wr_preg[i];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////

    // reads see the table before this cycle's writes
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            prs1[i]    = map_q[rs1[i]];
            prs2[i]    = map_q[rs2[i]];
            old_prd[i] = map_q[rd[i]];
        end
    end

endmodule

//--- hdl/rename_pkg.sv
package rename_pkg;

    //////////////////////////////////////////////////
    // machine sizes
    //////////////////////////////////////////////////

    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;
    localparam int ROB_DEPTH = 32;

    localparam int AREG_W = $clog2(ARCH_REGS);
    localparam int PREG_W = $clog2(PHYS_REGS);
    localparam int ROB_W  = $clog2(ROB_DEPTH);

    //////////////////////////////////////////////////
    // register and rob numbers
    //////////////////////////////////////////////////

    // architectural register number
    typedef logic [AREG_W-1:0] areg_t;

    // physical register number, 0 is the hardwired zero
    typedef logic [PREG_W-1:0] preg_t;

    // rob entry index with the wrap-direction bit on top
    typedef logic [ROB_W:0] rob_idx_t;

endpackage
